// ==== rtl/bmu_pkg.sv ====
// --------------------
// Shared definitions of the bit manipulation unit
// Default datapath width, class and sub-operation enums
// Operation struct carried from the issue port to every unit
// --------------------

package bmu_pkg;

    // Default datapath width, any multiple of 8 from 16 up
    localparam int bmu_xlen_default = 32;

    // --------------------
    // Result path select
    // --------------------
    typedef enum logic [2:0] {
        SHADD   = 3'd0,
        BITOP   = 3'd1,
        COUNT   = 3'd2,
        COMPARE = 3'd3,
        EXTEND  = 3'd4,
        ROTATE  = 3'd5,
        BYTEOP  = 3'd6
    } bmu_class_e;

    // --------------------
    // Sub-operations, one enum per class
    // --------------------

    // Shift amount of operand A is 1, 2 or 3
    typedef enum logic [1:0] {
        SH1ADD = 2'd0,
        SH2ADD = 2'd1,
        SH3ADD = 2'd2
    } bmu_shadd_e;

    // Immediate bit forms map onto the register forms
    typedef enum logic [2:0] {
        ANDN = 3'd0,
        ORN  = 3'd1,
        XNOR = 3'd2,
        BCLR = 3'd3,
        BEXT = 3'd4,
        BINV = 3'd5,
        BSET = 3'd6
    } bmu_bitop_e;

    typedef enum logic [1:0] {
        CLZ  = 2'd0,
        CTZ  = 2'd1,
        CPOP = 2'd2
    } bmu_count_e;

    typedef enum logic [1:0] {
        MAX  = 2'd0,
        MAXU = 2'd1,
        MIN  = 2'd2,
        MINU = 2'd3
    } bmu_compare_e;

    typedef enum logic [1:0] {
        SEXTB = 2'd0,
        SEXTH = 2'd1,
        ZEXTH = 2'd2
    } bmu_extend_e;

    typedef enum logic {
        ROL = 1'b0,
        ROR = 1'b1
    } bmu_rotate_e;

    typedef enum logic {
        REV8 = 1'b0,
        ORCB = 1'b1
    } bmu_byteop_e;

    // Only the field that matches op_class carries meaning
    typedef struct packed {
        bmu_class_e   op_class;
        bmu_shadd_e   shadd;
        bmu_bitop_e   bitop;
        bmu_count_e   count;
        bmu_compare_e compare;
        bmu_extend_e  extend;
        bmu_rotate_e  rotate;
        bmu_byteop_e  byteop;
    } bmu_op_t;

endpackage : bmu_pkg

// ==== rtl/bmu_arith_unit.sv ====
// --------------------
// Arithmetic unit: sh1add, sh2add, sh3add
// Signed and unsigned min and max
// --------------------

`timescale 1ns/1ps

module bmu_arith_unit #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input  logic             clk_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  bmu_pkg::bmu_op_t op_i,
    output logic [XLEN-1:0]  result_o
);

    // --------------------
    // Shift and add
    // --------------------
    logic [1:0]      shamt;
    logic [XLEN-1:0] shadd_result;

    always_comb begin : shamt_decode
        // Unused encoding falls back to a shift of 1
        case (op_i.shadd)
            bmu_pkg::SH2ADD: shamt = 2'd2;
            bmu_pkg::SH3ADD: shamt = 2'd3;
            default:         shamt = 2'd1;
        endcase
    end : shamt_decode

    // Carry out of the top bit is dropped
    assign shadd_result = operand_b_i + (operand_a_i << shamt);

    // --------------------
    // Min and max
    // --------------------
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] compare_result;

    // One comparator per signedness, shared by min and max
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;

    always_comb begin : compare_select
        case (op_i.compare)
            bmu_pkg::MAX:  compare_result = lt_signed   ? operand_b_i : operand_a_i;
            bmu_pkg::MAXU: compare_result = lt_unsigned ? operand_b_i : operand_a_i;
            bmu_pkg::MIN:  compare_result = lt_signed   ? operand_a_i : operand_b_i;
            default:       compare_result = lt_unsigned ? operand_a_i : operand_b_i;
        endcase
    end : compare_select

    // Stage register, loaded every cycle
    // Class picks which half of the unit is captured
    always_ff @(posedge clk_i) begin : stage_register
        if (op_i.op_class == bmu_pkg::COMPARE) begin
            result_o <= compare_result;
        end else begin
            result_o <= shadd_result;
        end
    end : stage_register

endmodule : bmu_arith_unit

// ==== rtl/bmu_bit_unit.sv ====
// --------------------
// Bit unit: andn, orn, xnor
// Single-bit clear, extract, invert and set
// --------------------

`timescale 1ns/1ps

module bmu_bit_unit #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input  logic             clk_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  bmu_pkg::bmu_op_t op_i,
    output logic [XLEN-1:0]  result_o
);

    localparam int IDXW = $clog2(XLEN);

    // --------------------
    // Logic with inverted operand
    // --------------------
    logic [XLEN-1:0] andn_result;
    logic [XLEN-1:0] orn_result;
    logic [XLEN-1:0] xnor_result;

    assign andn_result = operand_a_i & ~operand_b_i;
    assign orn_result  = operand_a_i | ~operand_b_i;
    assign xnor_result = ~(operand_a_i ^ operand_b_i);

    // --------------------
    // Single-bit operations
    // --------------------
    logic [IDXW-1:0] index;
    logic [XLEN-1:0] bit_mask;
    logic [XLEN-1:0] bclr_result;
    logic [XLEN-1:0] bext_result;
    logic [XLEN-1:0] binv_result;
    logic [XLEN-1:0] bset_result;

    // Upper bits of B are ignored, immediate forms land here too
    assign index = operand_b_i[IDXW-1:0];

    // One-hot mask at the selected position
    assign bit_mask = {{(XLEN-1){1'b0}}, 1'b1} << index;

    assign bclr_result = operand_a_i & ~bit_mask;
    assign binv_result = operand_a_i ^ bit_mask;
    assign bset_result = operand_a_i | bit_mask;

    // Selected bit moves to bit 0, rest zero
    assign bext_result = {{(XLEN-1){1'b0}}, operand_a_i[index]};

    // Stage register, selection by the bitop field only
    always_ff @(posedge clk_i) begin : stage_register
        case (op_i.bitop)
            bmu_pkg::ANDN: result_o <= andn_result;
            bmu_pkg::ORN:  result_o <= orn_result;
            bmu_pkg::XNOR: result_o <= xnor_result;
            bmu_pkg::BCLR: result_o <= bclr_result;
            bmu_pkg::BEXT: result_o <= bext_result;
            bmu_pkg::BINV: result_o <= binv_result;
            bmu_pkg::BSET: result_o <= bset_result;
            // Unused encoding returns zero
            default:       result_o <= '0;
        endcase
    end : stage_register

endmodule : bmu_bit_unit

// ==== rtl/bmu_count_unit.sv ====
// --------------------
// Count unit: clz, ctz and cpop
// Narrow count register, zero padded to XLEN
// --------------------

`timescale 1ns/1ps

module bmu_count_unit #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input  logic             clk_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  bmu_pkg::bmu_op_t op_i,
    output logic [XLEN-1:0]  result_o
);

    localparam int IDXW  = $clog2(XLEN);
    // One extra bit so that XLEN itself fits
    localparam int CNTW  = IDXW + 1;
    localparam int BYTES = XLEN / 8;

    // --------------------
    // Leading and trailing zeros
    // --------------------
    logic [XLEN-1:0] reversed_a;
    logic [XLEN-1:0] zero_operand;
    logic [IDXW-1:0] lz_count;
    logic            all_zero;
    logic [CNTW-1:0] zeros_result;

    // Trailing zeros of A are the leading zeros of A reversed
    always_comb begin : bit_reverse
        for (int i = 0; i < XLEN; i++) begin
            reversed_a[XLEN-1-i] = operand_a_i[i];
        end
    end : bit_reverse

    assign zero_operand = (op_i.count == bmu_pkg::CLZ) ? operand_a_i : reversed_a;

    // Priority encoder, highest set bit wins
    always_comb begin : lz_encoder
        lz_count = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (zero_operand[i]) begin
                lz_count = IDXW'(XLEN - 1 - i);
            end
        end
    end : lz_encoder

    assign all_zero     = ~|zero_operand;
    // All-zero operand counts the full width
    assign zeros_result = all_zero ? CNTW'(XLEN) : {1'b0, lz_count};

    // --------------------
    // Population count
    // --------------------
    logic [BYTES-1:0][3:0] byte_pop;
    logic [CNTW-1:0]       pop_result;

    // First level, one small count per byte
    always_comb begin : byte_count
        byte_pop = '0;
        for (int b = 0; b < BYTES; b++) begin
            for (int i = 0; i < 8; i++) begin
                byte_pop[b] = byte_pop[b] + 4'(operand_a_i[8*b+i]);
            end
        end
    end : byte_count

    // Second level sums the byte counts
    always_comb begin : byte_sum
        pop_result = '0;
        for (int b = 0; b < BYTES; b++) begin
            pop_result = pop_result + CNTW'(byte_pop[b]);
        end
    end : byte_sum

    // Only CNTW bits are stored
    logic [CNTW-1:0] count_q;

    always_ff @(posedge clk_i) begin : stage_register
        count_q <= (op_i.count == bmu_pkg::CPOP) ? pop_result : zeros_result;
    end : stage_register

    // Upper result bits are always zero
    assign result_o = {{(XLEN-CNTW){1'b0}}, count_q};

endmodule : bmu_count_unit

// ==== rtl/bmu_permute_unit.sv ====
// --------------------
// Permute unit: rol, ror, rev8, orc.b
// Sign and zero extension of byte and halfword
// --------------------

`timescale 1ns/1ps

module bmu_permute_unit #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input  logic             clk_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  bmu_pkg::bmu_op_t op_i,
    output logic [XLEN-1:0]  result_o
);

    localparam int IDXW  = $clog2(XLEN);
    localparam int BYTES = XLEN / 8;

    // --------------------
    // Rotates
    // --------------------
    logic [IDXW-1:0]   rot_amount;
    logic [2*XLEN-1:0] rol_wide;
    logic [2*XLEN-1:0] ror_wide;
    logic [XLEN-1:0]   rotate_result;

    assign rot_amount = operand_b_i[IDXW-1:0];

    // Doubled operand, bits shifted out of one copy enter from the other
    assign rol_wide = {operand_a_i, operand_a_i} << rot_amount;
    assign ror_wide = {operand_a_i, operand_a_i} >> rot_amount;

    assign rotate_result = (op_i.rotate == bmu_pkg::ROL) ? rol_wide[2*XLEN-1:XLEN]
                                                         : ror_wide[XLEN-1:0];

    // --------------------
    // Byte operations
    // --------------------
    logic [BYTES-1:0][7:0] bytes_a;
    logic [BYTES-1:0][7:0] rev8_result;
    logic [BYTES-1:0][7:0] orcb_result;
    logic [XLEN-1:0]       byteop_result;

    assign bytes_a = operand_a_i;

    always_comb begin : byte_logic
        for (int b = 0; b < BYTES; b++) begin
            // Byte order reversed end to end
            rev8_result[BYTES-1-b] = bytes_a[b];
            // Any set bit fills the byte with ones
            orcb_result[b] = {8{|bytes_a[b]}};
        end
    end : byte_logic

    assign byteop_result = (op_i.byteop == bmu_pkg::REV8) ? rev8_result : orcb_result;

    // --------------------
    // Extensions
    // --------------------
    logic [XLEN-1:0] extend_result;

    always_comb begin : extend_select
        case (op_i.extend)
            bmu_pkg::SEXTB: extend_result = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
            bmu_pkg::SEXTH: extend_result = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
            // zext.h and the unused code
            default:        extend_result = {{(XLEN-16){1'b0}}, operand_a_i[15:0]};
        endcase
    end : extend_select

    // Stage register, class picks the path
    always_ff @(posedge clk_i) begin : stage_register
        case (op_i.op_class)
            bmu_pkg::ROTATE: result_o <= rotate_result;
            bmu_pkg::BYTEOP: result_o <= byteop_result;
            default:         result_o <= extend_result;
        endcase
    end : stage_register

endmodule : bmu_permute_unit

// ==== rtl/bmu_top.sv ====
// --------------------
// Bit manipulation unit top level
// Four registered datapath units, control stage
// Final result multiplexer on the registered class
// --------------------

`timescale 1ns/1ps

module bmu_top #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [XLEN-1:0]  operand_a_i,
    input  logic [XLEN-1:0]  operand_b_i,
    input  bmu_pkg::bmu_op_t op_i,
    input  logic             valid_i,
    output logic [XLEN-1:0]  result_o,
    output logic             valid_o
);

    // Registered unit results, all one cycle after issue
    logic [XLEN-1:0] arith_result;
    logic [XLEN-1:0] bit_result;
    logic [XLEN-1:0] count_result;
    logic [XLEN-1:0] permute_result;

    // --------------------
    // Datapath units
    // --------------------

    // Operands and op fan out to every unit
    bmu_arith_unit #(.XLEN(XLEN)) u_arith (
        .clk_i       (clk_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .result_o    (arith_result)
    );

    bmu_bit_unit #(.XLEN(XLEN)) u_bit (
        .clk_i       (clk_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .result_o    (bit_result)
    );

    bmu_count_unit #(.XLEN(XLEN)) u_count (
        .clk_i       (clk_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .result_o    (count_result)
    );

    bmu_permute_unit #(.XLEN(XLEN)) u_permute (
        .clk_i       (clk_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .result_o    (permute_result)
    );

    // --------------------
    // Control stage
    // --------------------
    bmu_pkg::bmu_class_e class_q;

    // Class follows the operands into the stage
    always_ff @(posedge clk_i) begin : class_register
        class_q <= op_i.op_class;
    end : class_register

    // Output strobe, no back-pressure
    always_ff @(posedge clk_i) begin : valid_register
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end : valid_register

    // Final result select
    always_comb begin : result_mux
        case (class_q)
            bmu_pkg::SHADD,
            bmu_pkg::COMPARE: result_o = arith_result;
            bmu_pkg::BITOP:   result_o = bit_result;
            bmu_pkg::COUNT:   result_o = count_result;
            bmu_pkg::EXTEND,
            bmu_pkg::ROTATE,
            bmu_pkg::BYTEOP:  result_o = permute_result;
            default:          result_o = '0;
        endcase
    end : result_mux

endmodule : bmu_top

// ==== tests/bmu_assertions.sv ====
// --------------------
// Bound assertions for the bit manipulation unit top level
// Valid timing after reset and issue, count result range
// --------------------

`timescale 1ns/1ps

module bmu_assertions #(
    parameter int XLEN = bmu_pkg::bmu_xlen_default
) (
    input logic                clk_i,
    input logic                reset_i,
    input logic                valid_i,
    input logic                valid_o,
    input logic [XLEN-1:0]     result_o,
    input bmu_pkg::bmu_class_e class_q
);

    // Number of failed assertions so far
    int error_count = 0;

    // Output strobe cleared one cycle after reset
    property reset_clears_valid;
        @(posedge clk_i) reset_i |=> !valid_o;
    endproperty

    // Out of reset the strobe is the input strobe one cycle late
    property valid_follows_issue;
        @(posedge clk_i) !reset_i |=> (valid_o == $past(valid_i));
    endproperty

    // A count never exceeds the datapath width
    property count_in_range;
        @(posedge clk_i) (valid_o && class_q == bmu_pkg::COUNT) |-> (result_o <= XLEN);
    endproperty

    reset_clears_valid_a : assert property (reset_clears_valid)
    else begin
        error_count++;
        $error("valid_o high in the cycle after reset");
    end

    valid_follows_issue_a : assert property (valid_follows_issue)
    else begin
        error_count++;
        $error("valid_o does not match valid_i of the previous cycle");
    end

    count_in_range_a : assert property (count_in_range)
    else begin
        error_count++;
        $error("count result %0d exceeds %0d", result_o, XLEN);
    end

endmodule : bmu_assertions

bind bmu_top bmu_assertions #(.XLEN(XLEN)) u_assertions (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .class_q  (class_q)
);

// ==== tests/bmu_tb.sv ====
// --------------------
// Testbench for the bit manipulation unit
// Clock, reset, directed and random stimulus, reference model
// In-order result checks and watchdog
// --------------------

`timescale 1ns/1ps

module bmu_tb;

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_RANDOM = 300;
    // Directed issues: 2 idle, 63 corner, 15 count, 32 single-bit, 36 permute
    localparam int NUM_OPS    = 148 + NUM_RANDOM;

    logic             clk_i;
    logic             reset_i;
    logic [XLEN-1:0]  operand_a_i;
    logic [XLEN-1:0]  operand_b_i;
    bmu_pkg::bmu_op_t op_i;
    logic             valid_i;
    logic [XLEN-1:0]  result_o;
    logic             valid_o;

    // Expected results in issue order, with the behavior name
    logic [XLEN-1:0] expected_q [$];
    string           name_q [$];
    logic [31:0]     rng_state = 32'd82843;

    logic [31:0] corner_vals [3] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000};
    logic [31:0] count_vals [5]  = '{32'h0, 32'hFFFF_FFFF, 32'h1, 32'h0001_0000, 32'h8000_0000};
    logic [31:0] index_vals [4]  = '{32'h0, 32'd31, 32'hFFFF_FFE0, 32'h0000_0FDF};
    logic [31:0] perm_vals [4]   = '{32'h8123_4567, 32'h0000_0080, 32'h1234_8000, 32'h0080_7F01};

    bmu_top #(.XLEN(XLEN)) dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .valid_i     (valid_i),
        .result_o    (result_o),
        .valid_o     (valid_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end : clock_gen

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Builds an op with only the class and its own field set
    function automatic bmu_pkg::bmu_op_t make_op(input bmu_pkg::bmu_class_e cls,
                                                 input int unsigned sub);
        bmu_pkg::bmu_op_t op;
        op = '0;
        op.op_class = cls;
        case (cls)
            bmu_pkg::SHADD:   op.shadd   = bmu_pkg::bmu_shadd_e'(sub % 3);
            bmu_pkg::BITOP:   op.bitop   = bmu_pkg::bmu_bitop_e'(sub % 7);
            bmu_pkg::COUNT:   op.count   = bmu_pkg::bmu_count_e'(sub % 3);
            bmu_pkg::COMPARE: op.compare = bmu_pkg::bmu_compare_e'(sub % 4);
            bmu_pkg::EXTEND:  op.extend  = bmu_pkg::bmu_extend_e'(sub % 3);
            bmu_pkg::ROTATE:  op.rotate  = bmu_pkg::bmu_rotate_e'(sub % 2);
            default:          op.byteop  = bmu_pkg::bmu_byteop_e'(sub % 2);
        endcase
        return op;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [XLEN-1:0] reference(input bmu_pkg::bmu_op_t op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        int              idx;
        int              n;
        r   = a;
        idx = b % XLEN;
        n   = 0;
        case (op.op_class)
            bmu_pkg::SHADD: r = b + (a << (int'(op.shadd) + 1));
            bmu_pkg::BITOP: begin
                case (op.bitop)
                    bmu_pkg::ANDN: r = a & ~b;
                    bmu_pkg::ORN:  r = a | ~b;
                    bmu_pkg::XNOR: r = a ~^ b;
                    bmu_pkg::BCLR: r[idx] = 1'b0;
                    bmu_pkg::BEXT: r = XLEN'(a[idx]);
                    bmu_pkg::BINV: r[idx] = ~a[idx];
                    default:       r[idx] = 1'b1;
                endcase
            end
            bmu_pkg::COUNT: begin
                // Zeros counted from the top for clz, from bit 0 for ctz
                if (op.count == bmu_pkg::CPOP) begin
                    n = $countones(a);
                end else if (op.count == bmu_pkg::CLZ) begin
                    while (n < XLEN && !a[XLEN-1-n]) n++;
                end else begin
                    while (n < XLEN && !a[n]) n++;
                end
                r = XLEN'(n);
            end
            bmu_pkg::COMPARE: begin
                case (op.compare)
                    bmu_pkg::MAX:  r = ($signed(a) > $signed(b)) ? a : b;
                    bmu_pkg::MAXU: r = (a > b) ? a : b;
                    bmu_pkg::MIN:  r = ($signed(a) < $signed(b)) ? a : b;
                    default:       r = (a < b) ? a : b;
                endcase
            end
            bmu_pkg::EXTEND: begin
                if (op.extend == bmu_pkg::SEXTB) r = XLEN'($signed(a[7:0]));
                else if (op.extend == bmu_pkg::SEXTH) r = XLEN'($signed(a[15:0]));
                else r = XLEN'(a[15:0]);
            end
            bmu_pkg::ROTATE: begin
                if (op.rotate == bmu_pkg::ROL) r = (a << idx) | (a >> (XLEN - idx));
                else r = (a >> idx) | (a << (XLEN - idx));
            end
            default: begin
                for (int k = 0; k < XLEN / 8; k++) begin
                    if (op.byteop == bmu_pkg::REV8) r[8*k +: 8] = a[XLEN-8-8*k +: 8];
                    else r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hFF : 8'h00;
                end
            end
        endcase
        return r;
    endfunction

    // Drives one operation for one cycle, called 1 ns after an edge
    task automatic issue_op(input string name, input bmu_pkg::bmu_op_t op,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        valid_i     = 1'b1;
        expected_q.push_back(reference(op, a, b));
        name_q.push_back(name);
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        valid_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // --------------------
    // Checks
    // --------------------

    // Results compared mid-cycle, away from the driving edge
    always @(negedge clk_i) begin : result_check
        logic [XLEN-1:0] expected;
        string           name;
        if (valid_o === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("ERROR: valid_o high with no operation outstanding");
                $display("Testbench failed");
                $fatal(1, "unexpected result strobe");
            end else begin
                expected = expected_q.pop_front();
                name     = name_q.pop_front();
                if (result_o !== expected) begin
                    $display("CHECK FAILED %s expected %h actual %h", name, expected, result_o);
                    $display("Testbench failed");
                    $fatal(1, "result mismatch");
                end
            end
        end
    end : result_check

    initial begin : assertion_monitor
        wait (dut.u_assertions.error_count != 0);
        $display("ERROR: a bound assertion on bmu_top failed");
        $display("Testbench failed");
        $fatal(1, "assertion failure");
    end : assertion_monitor

    initial begin : watchdog
        #((NUM_OPS + 200) * CLK_PERIOD);
        $display("ERROR: run hung, results did not drain before the time limit");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end : watchdog

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        operand_a_i = '0;
        operand_b_i = '0;
        op_i        = '0;
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // Isolated issues between idle gaps
        idle_cycles(4);
        issue_op("reset_idle", make_op(bmu_pkg::BITOP, 0), 32'hF0F0_1234, 32'h0FF0_0034);
        idle_cycles(3);
        issue_op("reset_idle", make_op(bmu_pkg::COUNT, 2), 32'h0000_00FF, 32'h0);
        idle_cycles(2);

        // Corner operands for shift-and-add and min/max
        foreach (corner_vals[i]) begin
            foreach (corner_vals[j]) begin
                for (int s = 0; s < 3; s++) begin
                    issue_op("corner_shadd", make_op(bmu_pkg::SHADD, s),
                             corner_vals[i], corner_vals[j]);
                end
                for (int s = 0; s < 4; s++) begin
                    issue_op("corner_compare", make_op(bmu_pkg::COMPARE, s),
                             corner_vals[i], corner_vals[j]);
                end
            end
        end

        foreach (count_vals[i]) begin
            for (int s = 0; s < 3; s++) begin
                issue_op("count", make_op(bmu_pkg::COUNT, s), count_vals[i], 32'h0);
            end
        end

        // bclr, bext, binv, bset at bit 0 and 31, upper B bits set too
        for (int k = 0; k < 2; k++) begin
            foreach (index_vals[j]) begin
                for (int s = 3; s < 7; s++) begin
                    issue_op("single_bit", make_op(bmu_pkg::BITOP, s),
                             k ? 32'h7FFF_FFFE : 32'h8000_0001, index_vals[j]);
                end
            end
        end

        foreach (perm_vals[i]) begin
            for (int s = 0; s < 2; s++) begin
                issue_op("rotate", make_op(bmu_pkg::ROTATE, s), perm_vals[i], 32'd0);
                issue_op("rotate", make_op(bmu_pkg::ROTATE, s), perm_vals[i], 32'd31);
                issue_op("byteop", make_op(bmu_pkg::BYTEOP, s), perm_vals[i], 32'h0);
            end
            for (int s = 0; s < 3; s++) begin
                issue_op("extend", make_op(bmu_pkg::EXTEND, s), perm_vals[i], 32'h0);
            end
        end

        // Back-to-back random issue over all seven classes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            issue_op("random", make_op(bmu_pkg::bmu_class_e'(next_random() % 7), next_random()),
                     next_random(), next_random());
        end

        while (expected_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);

        if (dut.u_assertions.error_count != 0) begin
            $display("Testbench failed");
            $fatal(1, "assertion failure at end of run");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end : stimulus

endmodule : bmu_tb

// ==== bmu_top.f ====
rtl/bmu_pkg.sv
rtl/bmu_arith_unit.sv
rtl/bmu_bit_unit.sv
rtl/bmu_count_unit.sv
rtl/bmu_permute_unit.sv
rtl/bmu_top.sv
tests/bmu_assertions.sv
tests/bmu_tb.sv
